// File: bench/tb_spi2gpio.sv
// testbench for the spi to gpio bridge
// spi master tasks, register map reference model and self checks
`timescale 1ns/1ps

module tb_spi2gpio import spi_proto_pkg::*, gpio_regmap_pkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int RST_CYCLES = 5;
	// clk cycles per spi phase
	localparam int HALF = 8;
	// writes, reads, illegal accesses, abandoned pairs
	localparam int NUM_FRAMES = 2 * NUM_PORTS + 3 * NUM_PORTS + 16 + 3 * NUM_PORTS + 8;
	// two bytes of 16 phases each, plus select setup, hold and gap
	localparam int FRAME_PHASES = 2 * 16 + 3;
	localparam int TIMEOUT_NS = (NUM_FRAMES * FRAME_PHASES * HALF + 2000) * CLK_PERIOD;
	// all ports input, port Z bit 7 high
	localparam gpio_bank_t EXP_RST = {8'h80, 40'h0};

	logic       clk;
	logic       rst_n;
	logic       spi_clk, spi_cs_n, spi_mosi;
	gpio_bank_t gpio_in;
	logic       spi_miso, spi_miso_oe;
	gpio_bank_t gpio_oe, gpio_out;

	// model state and prng
	gpio_bank_t  model_oe, model_out;
	logic [31:0] rng;

	// frame results for the checker
	event      frame_done;
	spi_byte_t got_cmd, got_data, exp_data;
	logic      data_valid;

	spi2gpio_bridge dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_spi_clk     (spi_clk),
		.i_spi_cs_n    (spi_cs_n),
		.i_spi_mosi    (spi_mosi),
		.i_gpio_in     (gpio_in),
		.o_spi_miso    (spi_miso),
		.o_spi_miso_oe (spi_miso_oe),
		.o_gpio_oe     (gpio_oe),
		.o_gpio_out    (gpio_out)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] rand32();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic spi_byte_t rand_byte();
		logic [31:0] r;
		r = rand32();
		return r[7:0];
	endfunction

	// slots 0..4 hold ports A..E, slot 7 holds Z
	function automatic logic slot_mapped(input logic [2:0] slot);
		return slot <= 3'd4 || slot == 3'd7;
	endfunction

	function automatic logic [2:0] slot_index(input logic [2:0] slot);
		return (slot == 3'd7) ? 3'd5 : slot;
	endfunction

	function automatic reg_addr_t port_addr(input logic [2:0] port, input gpio_field_e f);
		logic [2:0] s;
		s = (port == 3'd5) ? 3'd7 : port;
		return {s, f};
	endfunction

	function automatic spi_byte_t make_cmd(input logic wr, input reg_addr_t addr);
		spi_byte_t c;
		c = {3'b000, addr};
		c[CMD_WRITE_BIT] = wr;
		return c;
	endfunction

	// reference model
	// readback, unmapped slots and reserved field give zero
	function automatic spi_byte_t ref_read(input reg_addr_t addr, input gpio_bank_t oe,
		input gpio_bank_t out, input gpio_bank_t in);
		spi_byte_t v;
		v = 8'h00;
		if (slot_mapped(addr[4:2])) begin
			case (gpio_field_e'(addr[1:0]))
				FIELD_OE:  v = oe[slot_index(addr[4:2])];
				FIELD_OUT: v = out[slot_index(addr[4:2])];
				FIELD_IN:  v = in[slot_index(addr[4:2])];
				default:   v = 8'h00;
			endcase
		end
		return v;
	endfunction

	// only a matching field of a mapped port changes
	function automatic gpio_bank_t ref_write(input gpio_bank_t bank, input reg_addr_t addr,
		input gpio_field_e field, input spi_byte_t data);
		gpio_bank_t b;
		b = bank;
		if (slot_mapped(addr[4:2]) && gpio_field_e'(addr[1:0]) == field)
			b[slot_index(addr[4:2])] = data;
		return b;
	endfunction

	task automatic check_byte(input string name, input spi_byte_t exp, input spi_byte_t got);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s expected %h got %h", $time, name, exp, got);
			$display("FAIL: see errors above");
			$fatal(1, "readback mismatch");
		end
	endtask

	task automatic check_bank(input string name, input gpio_bank_t exp, input gpio_bank_t got);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s expected %h got %h", $time, name, exp, got);
			$display("FAIL: see errors above");
			$fatal(1, "port mismatch");
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s expected %b got %b", $time, name, exp, got);
			$display("FAIL: see errors above");
			$fatal(1, "level mismatch");
		end
	endtask

	// one byte msb first, sclk idle low
	// miso sampled on the falling clk just before each sclk rise
	task automatic spi_xfer(input spi_byte_t tx, output spi_byte_t rx);
		spi_byte_t sh;
		sh = tx;
		rx = 8'h00;
		for (int i = 0; i < SPI_BITS; i++) begin
			spi_mosi <= sh[SPI_BITS-1];
			sh = sh << 1;
			repeat (HALF - 1) @(posedge clk);
			@(negedge clk);
			rx = {rx[SPI_BITS-2:0], spi_miso};
			@(posedge clk);
			spi_clk <= 1'b1;
			repeat (HALF) @(posedge clk);
			spi_clk <= 1'b0;
		end
	endtask

	// full frames carry two bytes, abandoned ones only the command
	task automatic spi_frame(input spi_byte_t cmd, input spi_byte_t data, input logic full);
		spi_byte_t rc;
		spi_byte_t rd;
		@(posedge clk);
		spi_cs_n <= 1'b0;
		repeat (HALF) @(posedge clk);
		// miso pad driven once select has passed the synchronizer
		check_level("o_spi_miso_oe", 1'b1, spi_miso_oe);
		spi_xfer(cmd, rc);
		rd = 8'h00;
		if (full)
			spi_xfer(data, rd);
		repeat (HALF) @(posedge clk);
		spi_cs_n <= 1'b1;
		repeat (HALF) @(posedge clk);
		got_cmd = rc;
		got_data = rd;
		data_valid = full;
	endtask

	task automatic write_reg(input reg_addr_t addr, input spi_byte_t data);
		spi_frame(make_cmd(1'b1, addr), data, 1'b1);
		model_oe = ref_write(model_oe, addr, FIELD_OE, data);
		model_out = ref_write(model_out, addr, FIELD_OUT, data);
		exp_data = SPI_DUMMY;
		-> frame_done;
		@(posedge clk);
	endtask

	// inputs stay stable through the frame, so predict afterwards
	task automatic read_reg(input reg_addr_t addr);
		spi_frame(make_cmd(1'b0, addr), 8'h00, 1'b1);
		exp_data = ref_read(addr, model_oe, model_out, gpio_in);
		-> frame_done;
		@(posedge clk);
	endtask

	task automatic abandon_frame(input spi_byte_t cmd);
		spi_frame(cmd, 8'h00, 1'b0);
		-> frame_done;
		@(posedge clk);
	endtask

	task automatic new_inputs();
		logic [31:0] lo;
		logic [31:0] hi;
		lo = rand32();
		hi = rand32();
		gpio_in <= {hi[15:0], lo};
	endtask

	// checker, runs after every frame
	always begin
		@(frame_done);
		check_byte("o_spi_miso command byte", SPI_DUMMY, got_cmd);
		if (data_valid)
			check_byte("o_spi_miso data byte", exp_data, got_data);
		check_bank("o_gpio_oe", model_oe, gpio_oe);
		check_bank("o_gpio_out", model_out, gpio_out);
		check_level("o_spi_miso_oe", 1'b0, spi_miso_oe);
	end

	initial begin
		reg_addr_t a;
		rng = 32'h4afc;
		rst_n = 1'b0;
		spi_clk = 1'b0;
		spi_cs_n = 1'b1;
		spi_mosi = 1'b0;
		gpio_in = '0;
		model_oe = EXP_RST;
		model_out = EXP_RST;
		repeat (RST_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		check_bank("o_gpio_oe", EXP_RST, gpio_oe);
		check_bank("o_gpio_out", EXP_RST, gpio_out);
		check_level("o_spi_miso_oe", 1'b0, spi_miso_oe);

		// oe and out of every port
		for (int p = 0; p < NUM_PORTS; p++) begin
			write_reg(port_addr(3'(p), FIELD_OE), rand_byte());
			write_reg(port_addr(3'(p), FIELD_OUT), rand_byte());
		end

		// readback with fresh pin values each time
		for (int p = 0; p < NUM_PORTS; p++) begin
			new_inputs();
			read_reg(port_addr(3'(p), FIELD_OE));
			new_inputs();
			read_reg(port_addr(3'(p), FIELD_OUT));
			new_inputs();
			read_reg(port_addr(3'(p), FIELD_IN));
		end

		// slots 5 and 6, every field
		for (int i = 20; i < 28; i++) begin
			write_reg(reg_addr_t'(i), rand_byte());
			read_reg(reg_addr_t'(i));
		end
		// read only and reserved fields of mapped ports
		for (int p = 0; p < NUM_PORTS; p++) begin
			write_reg(port_addr(3'(p), FIELD_IN), rand_byte());
			write_reg(port_addr(3'(p), FIELD_RSVD), rand_byte());
			read_reg(port_addr(3'(p), FIELD_RSVD));
		end

		// dropped frames, next byte must decode as a command
		for (int k = 0; k < 2; k++) begin
			a = reg_addr_t'(rand_byte());
			abandon_frame(make_cmd(1'b1, a));
			write_reg(port_addr(3'(k), FIELD_OUT), rand_byte());
			a = reg_addr_t'(rand_byte());
			abandon_frame(make_cmd(1'b0, a));
			read_reg(port_addr(3'(k + 2), FIELD_OE));
		end

		$display("PASS: all tests");
		$finish;
	end

	// watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the test sequence did not complete in time");
		$display("FAIL: see errors above");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: rtl/gpio_regmap_pkg.sv
// gpio register map definitions
// port layout, field encoding, address split and reset values
package gpio_regmap_pkg;

	// address = {slot, field}
	localparam int FIELD_W = 2;
	localparam int SLOT_W = spi_proto_pkg::ADDR_W - FIELD_W;

	typedef logic [spi_proto_pkg::ADDR_W-1:0] reg_addr_t;
	typedef logic [SLOT_W-1:0] port_slot_t;

	// six ports, A B C D E Z
	localparam int NUM_PORTS = 6;
	localparam int PORT_W = 8;

	typedef logic [PORT_W-1:0] gpio_port_t;
	// index 0 is port A, index 5 is port Z
	typedef logic [NUM_PORTS-1:0][PORT_W-1:0] gpio_bank_t;

	// register within a port slot
	typedef enum logic [FIELD_W-1:0] {
		FIELD_OE   = 2'd0,
		FIELD_OUT  = 2'd1,
		FIELD_IN   = 2'd2,
		FIELD_RSVD = 2'd3
	} gpio_field_e;

	// slot of each port, slots 5 and 6 stay unmapped
	localparam port_slot_t PORT_SLOT [NUM_PORTS] = '{
		3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd7
	};

	// everything input, except port Z bit 7 driven high
	localparam gpio_bank_t RST_OE  = {8'h80, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
	localparam gpio_bank_t RST_OUT = {8'h80, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};

	// upper address bits select the port
	function automatic port_slot_t addr_slot(input reg_addr_t addr);
		return addr[spi_proto_pkg::ADDR_W-1:FIELD_W];
	endfunction

	// lower address bits select the register
	function automatic gpio_field_e addr_field(input reg_addr_t addr);
		return gpio_field_e'(addr[FIELD_W-1:0]);
	endfunction

	// a port reads back through this type
	function automatic gpio_port_t port_of(input gpio_bank_t bank, input int idx);
		return bank[idx];
	endfunction

endpackage

// File: rtl/gpio_regs.sv
// gpio register file
// oe and out registers per port, readback mux into the spi transmit byte
`timescale 1ns/1ps

module gpio_regs import spi_proto_pkg::*, gpio_regmap_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       i_rd_strobe,
	input  logic       i_wr_strobe,
	input  logic       i_data_done,
	input  reg_addr_t  i_rd_addr,
	input  reg_addr_t  i_wr_addr,
	input  spi_byte_t  i_wr_data,
	input  gpio_bank_t i_gpio_in,
	output gpio_bank_t o_gpio_oe,
	output gpio_bank_t o_gpio_out,
	output spi_byte_t  o_tx_byte
);

	gpio_bank_t  oe_q;
	gpio_bank_t  out_q;
	spi_byte_t   tx_q;

	// address split for both paths
	port_slot_t  wr_slot;
	gpio_field_e wr_field;
	port_slot_t  rd_slot;
	gpio_field_e rd_field;
	spi_byte_t   rd_val;

	assign wr_slot  = addr_slot(i_wr_addr);
	assign wr_field = addr_field(i_wr_addr);
	assign rd_slot  = addr_slot(i_rd_addr);
	assign rd_field = addr_field(i_rd_addr);

	// write decode
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			oe_q  <= RST_OE;
			out_q <= RST_OUT;
		end else if (i_wr_strobe) begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				if (wr_slot == PORT_SLOT[p]) begin
					case (wr_field)
						FIELD_OE:  oe_q[p]  <= i_wr_data;
						FIELD_OUT: out_q[p] <= i_wr_data;
						// input and reserved fields are read only
						default: ;
					endcase
				end
			end
		end
	end

	// readback mux
	// unmapped slots fall through as zero
	always_comb begin
		rd_val = '0;
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (rd_slot == PORT_SLOT[p]) begin
				case (rd_field)
					FIELD_OE:  rd_val = port_of(oe_q, p);
					FIELD_OUT: rd_val = port_of(out_q, p);
					FIELD_IN:  rd_val = port_of(i_gpio_in, p);
					default:   rd_val = '0;
				endcase
			end
		end
	end

	// transmit byte
	// holds readback for one data byte, dummy otherwise
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			tx_q <= SPI_DUMMY;
		else if (i_rd_strobe)
			tx_q <= rd_val;
		else if (i_data_done)
			tx_q <= SPI_DUMMY;
	end

	assign o_gpio_oe  = oe_q;
	assign o_gpio_out = out_q;
	assign o_tx_byte  = tx_q;

	// readback never leaks into the next frame
	a_tx_dummy: assert property (
		@(posedge clk) disable iff (!rst_n)
		i_data_done && !i_rd_strobe |=> o_tx_byte == SPI_DUMMY
	);

endmodule

// File: rtl/spi2gpio_bridge.sv
// spi to gpio bridge top level
// spi slave path feeding a bank of six 8-bit gpio ports
`timescale 1ns/1ps

module spi2gpio_bridge import spi_proto_pkg::*, gpio_regmap_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       i_spi_clk,
	input  logic       i_spi_cs_n,
	input  logic       i_spi_mosi,
	input  gpio_bank_t i_gpio_in,
	output logic       o_spi_miso,
	output logic       o_spi_miso_oe,
	output gpio_bank_t o_gpio_oe,
	output gpio_bank_t o_gpio_out
);

	// synchronized pin events
	logic      sclk_rise;
	logic      cs_fall;
	logic      cs_rise;
	logic      mosi;

	// byte level
	spi_byte_t rx_byte;
	spi_byte_t tx_byte;
	logic      byte_done;

	// register access
	logic      rd_strobe;
	logic      wr_strobe;
	logic      data_done;
	reg_addr_t rd_addr;
	reg_addr_t wr_addr;
	spi_byte_t wr_data;

	// miso pad enabled while selected
	spi_sync u_sync (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_spi_clk   (i_spi_clk),
		.i_spi_cs_n  (i_spi_cs_n),
		.i_spi_mosi  (i_spi_mosi),
		.o_sclk_rise (sclk_rise),
		.o_cs_fall   (cs_fall),
		.o_cs_rise   (cs_rise),
		.o_sel       (o_spi_miso_oe),
		.o_mosi      (mosi)
	);

	spi_shifter u_shifter (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_sclk_rise (sclk_rise),
		.i_cs_fall   (cs_fall),
		.i_mosi      (mosi),
		.i_tx_byte   (tx_byte),
		.o_rx_byte   (rx_byte),
		.o_byte_done (byte_done),
		.o_miso      (o_spi_miso)
	);

	spi_frame_ctrl u_frame (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_byte_done (byte_done),
		.i_cs_rise   (cs_rise),
		.i_rx_byte   (rx_byte),
		.o_rd_strobe (rd_strobe),
		.o_wr_strobe (wr_strobe),
		.o_data_done (data_done),
		.o_rd_addr   (rd_addr),
		.o_wr_addr   (wr_addr),
		.o_wr_data   (wr_data)
	);

	gpio_regs u_regs (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_rd_strobe (rd_strobe),
		.i_wr_strobe (wr_strobe),
		.i_data_done (data_done),
		.i_rd_addr   (rd_addr),
		.i_wr_addr   (wr_addr),
		.i_wr_data   (wr_data),
		.i_gpio_in   (i_gpio_in),
		.o_gpio_oe   (o_gpio_oe),
		.o_gpio_out  (o_gpio_out),
		.o_tx_byte   (tx_byte)
	);

endmodule

// File: rtl/spi_frame_ctrl.sv
// spi frame control
// tracks command/data position, latches the write target, issues strobes
`timescale 1ns/1ps

module spi_frame_ctrl import spi_proto_pkg::*, gpio_regmap_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      i_byte_done,
	input  logic      i_cs_rise,
	input  spi_byte_t i_rx_byte,
	output logic      o_rd_strobe,
	output logic      o_wr_strobe,
	output logic      o_data_done,
	output reg_addr_t o_rd_addr,
	output reg_addr_t o_wr_addr,
	output spi_byte_t o_wr_data
);

	frame_state_e state;
	// write flag of the current command
	logic         wr_cmd_q;
	reg_addr_t    wr_addr_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= ST_ADDR;
			wr_cmd_q <= 1'b0;
		end else if (i_cs_rise) begin
			// deselect abandons any half frame
			state <= ST_ADDR;
		end else if (i_byte_done) begin
			case (state)
				ST_ADDR: begin
					state    <= ST_DATA;
					wr_cmd_q <= cmd_is_write(i_rx_byte);
				end
				default: state <= ST_ADDR;
			endcase
		end
	end

	// write address held across the data byte
	always_ff @(posedge clk) begin
		if (i_byte_done && state == ST_ADDR)
			wr_addr_q <= i_rx_byte[ADDR_W-1:0];
	end

	// read fires on the command byte itself
	assign o_rd_strobe = i_byte_done && state == ST_ADDR && !cmd_is_write(i_rx_byte);
	assign o_wr_strobe = i_byte_done && state == ST_DATA && wr_cmd_q;
	// read data byte finished, or frame dropped after its command
	assign o_data_done = (i_byte_done && state == ST_DATA && !wr_cmd_q)
		|| (i_cs_rise && state == ST_DATA);

	assign o_rd_addr = i_rx_byte[ADDR_W-1:0];
	assign o_wr_addr = wr_addr_q;
	assign o_wr_data = i_rx_byte;

	// a byte is either a read command or write data, never both
	a_strobe_excl: assert property (
		@(posedge clk) disable iff (!rst_n) !(o_rd_strobe && o_wr_strobe)
	);

endmodule

// File: rtl/spi_proto_pkg.sv
// spi frame protocol definitions
// byte type, frame position and command byte layout
package spi_proto_pkg;

	// bits per spi byte, msb first on the wire
	localparam int SPI_BITS = 8;

	typedef logic [SPI_BITS-1:0] spi_byte_t;

	// position within a two byte frame
	typedef enum logic {
		ST_ADDR = 1'b0,
		ST_DATA = 1'b1
	} frame_state_e;

	// register address carried in the low bits of the command byte
	localparam int ADDR_W = 5;

	// set for write, clear for read
	localparam int CMD_WRITE_BIT = 7;

	// shifted out whenever no readback is pending
	localparam spi_byte_t SPI_DUMMY = 8'h5A;

	// command byte decode
	function automatic logic cmd_is_write(input spi_byte_t cmd);
		return cmd[CMD_WRITE_BIT];
	endfunction

endpackage

// File: rtl/spi_shifter.sv
// spi byte shifter
// one shift register receives at the lsb while the msb goes out on miso
`timescale 1ns/1ps

module spi_shifter import spi_proto_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      i_sclk_rise,
	input  logic      i_cs_fall,
	input  logic      i_mosi,
	input  spi_byte_t i_tx_byte,
	output spi_byte_t o_rx_byte,
	output logic      o_byte_done,
	output logic      o_miso
);

	// one-hot bit position, bit 0 before the first edge
	logic [SPI_BITS:0] bit_cnt;
	spi_byte_t         shift_r;
	logic              done_q;
	// transmit load one cycle after the byte completes
	logic              load_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt <= (SPI_BITS+1)'(1);
			done_q  <= 1'b0;
			load_q  <= 1'b0;
		end else begin
			// 8th edge arrives while the top data bit is set
			done_q <= i_sclk_rise & bit_cnt[SPI_BITS-1];
			load_q <= done_q;
			if (i_cs_fall || load_q)
				bit_cnt <= (SPI_BITS+1)'(1);
			else if (i_sclk_rise)
				bit_cnt <= {bit_cnt[SPI_BITS-1:0], bit_cnt[SPI_BITS]};
		end
	end

	// payload, loaded at select and after every byte
	always_ff @(posedge clk) begin
		if (i_cs_fall || load_q)
			shift_r <= i_tx_byte;
		else if (i_sclk_rise)
			shift_r <= {shift_r[SPI_BITS-2:0], i_mosi};
	end

	// full byte sits in shift_r during the done pulse
	assign o_rx_byte   = shift_r;
	assign o_byte_done = done_q;
	assign o_miso      = shift_r[SPI_BITS-1];

	// counter never loses or duplicates its position bit
	a_cnt_onehot: assert property (
		@(posedge clk) disable iff (!rst_n) $onehot(bit_cnt)
	);

endmodule

// File: rtl/spi_sync.sv
// spi pin synchronizer
// brings sclk, cs_n and mosi into clk, makes edge pulses and select level
`timescale 1ns/1ps

module spi_sync (
	input  logic clk,
	input  logic rst_n,
	input  logic i_spi_clk,
	input  logic i_spi_cs_n,
	input  logic i_spi_mosi,
	output logic o_sclk_rise,
	output logic o_cs_fall,
	output logic o_cs_rise,
	output logic o_sel,
	output logic o_mosi
);

	// first stage on every pin
	logic sclk_s;
	logic cs_n_s;
	logic mosi_s;
	// previous sample for edge detect
	logic sclk_d;
	logic cs_n_d;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			// idle bus, deselected with clock low
			sclk_s <= 1'b0;
			cs_n_s <= 1'b1;
			mosi_s <= 1'b0;
			sclk_d <= 1'b0;
			cs_n_d <= 1'b1;
		end else begin
			sclk_s <= i_spi_clk;
			cs_n_s <= i_spi_cs_n;
			mosi_s <= i_spi_mosi;
			sclk_d <= sclk_s;
			cs_n_d <= cs_n_s;
		end
	end

	// rising sclk only counts while selected
	assign o_sclk_rise = sclk_s & ~sclk_d & ~cs_n_s;
	assign o_cs_fall   = ~cs_n_s & cs_n_d;
	assign o_cs_rise   = cs_n_s & ~cs_n_d;
	assign o_sel       = ~cs_n_s;
	assign o_mosi      = mosi_s;

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the spi2gpio testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_spi2gpio \
	-f spi2gpio_bridge.f -o tb_spi2gpio > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_spi2gpio > sim.log 2>&1
cat sim.log
! grep -q "FAIL: see errors above" sim.log && grep -q "PASS: all tests" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: spi2gpio_bridge.f
rtl/spi_proto_pkg.sv
rtl/gpio_regmap_pkg.sv
rtl/spi_sync.sv
rtl/spi_shifter.sv
rtl/spi_frame_ctrl.sv
rtl/gpio_regs.sv
rtl/spi2gpio_bridge.sv
bench/tb_spi2gpio.sv
